// File: Makefile
# Verilator build for the core shell testbench

VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_core_shell
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_clock_gen.sv
// Testbench clock and reset generator
// Free-running clock, reset held low for a number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: bench/tb_core_shell.sv
// Core shell testbench
// Applies a table of rows, one clock cycle each, and checks sleep,
// register file and scrambling key outputs against a reference model

`timescale 1ns/1ps

module tb_core_shell import shell_pkg::*; ();

  localparam int unsigned CLK_PERIOD   = 40;
  localparam int unsigned SAMPLE_DELAY = CLK_PERIOD / 2 - 5;

  localparam scramble_key_t   NEW_KEY   = 128'h5be0_cd19_137e_2179_6a4f_02d8_e1b3_9c75;
  localparam scramble_nonce_t NEW_NONCE = 64'hd2a7_4c01_96fe_38b5;

  // Wake vector bits {busy, debug, irq_en, software, timer, external, nmi}
  localparam logic [6:0] W_BUSY   = 7'b1000000;
  localparam logic [6:0] W_DEBUG  = 7'b0100000;
  localparam logic [6:0] W_IRQ_EN = 7'b0010000;
  localparam logic [6:0] W_SW     = 7'b0001000;
  localparam logic [6:0] W_TIMER  = 7'b0000100;
  localparam logic [6:0] W_EXT    = 7'b0000010;
  localparam logic [6:0] W_NM     = 7'b0000001;

  // Expected {sleep, req, key valid, new key}
  localparam logic [3:0] E_SLEEP = 4'b1010;
  localparam logic [3:0] E_AWAKE = 4'b0010;

  typedef enum logic [1:0] {OP_HOLD, OP_WRITE, OP_DROP} op_e;

  typedef struct packed {
    op_e                     op;
    logic [6:0]              wake;
    logic [NUM_FAST_IRQ-1:0] irq_fast;
    reg_addr_t               addr;
    logic [1:0]              key_in;   // {invalidate, key valid}
    logic [3:0]              exp_out;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    core_busy, debug_req, irq_en;
  logic                    irq_software, irq_timer, irq_external, irq_nm;
  logic [NUM_FAST_IRQ-1:0] irq_fast;
  logic                    core_sleep;
  reg_addr_t               rf_raddr_a, rf_raddr_b, rf_waddr;
  reg_data_t               rf_wdata, rf_rdata_a, rf_rdata_b;
  logic                    rf_we;
  logic                    key_invalidate, key_valid_in;
  scramble_key_t           scramble_key, key_out;
  scramble_nonce_t         scramble_nonce, nonce_out;
  logic                    scramble_req, scramble_key_valid;

  row_t      rows [$];
  reg_data_t model [NUM_REGS];
  int        seed;
  int        cur_row;
  logic      rows_ready;

  tb_clock_gen #(
    .PERIOD_NS   (CLK_PERIOD),
    .RESET_CYCLES(2)
  ) u_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  core_shell_top #(
    .RV32E(1'b0)
  ) uut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .core_busy_i         (core_busy),
    .debug_req_i         (debug_req),
    .irq_en_i            (irq_en),
    .irq_software_i      (irq_software),
    .irq_timer_i         (irq_timer),
    .irq_external_i      (irq_external),
    .irq_nm_i            (irq_nm),
    .irq_fast_i          (irq_fast),
    .core_sleep_o        (core_sleep),
    .rf_raddr_a_i        (rf_raddr_a),
    .rf_raddr_b_i        (rf_raddr_b),
    .rf_waddr_i          (rf_waddr),
    .rf_wdata_i          (rf_wdata),
    .rf_we_i             (rf_we),
    .rf_rdata_a_o        (rf_rdata_a),
    .rf_rdata_b_o        (rf_rdata_b),
    .key_invalidate_i    (key_invalidate),
    .scramble_key_valid_i(key_valid_in),
    .scramble_key_i      (scramble_key),
    .scramble_nonce_i    (scramble_nonce),
    .scramble_req_o      (scramble_req),
    .scramble_key_valid_o(scramble_key_valid),
    .key_o               (key_out),
    .nonce_o             (nonce_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Checking and row application
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      $display("Mismatch %s in row %0d: got %0h expected %0h",
               name, cur_row, actual, expected);
      $display("Checks failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input op_e op, input logic [6:0] wake,
                         input logic [NUM_FAST_IRQ-1:0] fast, input reg_addr_t addr,
                         input logic [1:0] key_in, input logic [3:0] exp_out);
    row_t r;
    r.op       = op;
    r.wake     = wake;
    r.irq_fast = fast;
    r.addr     = addr;
    r.key_in   = key_in;
    r.exp_out  = exp_out;
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    reg_data_t       exp_data;
    scramble_key_t   exp_key;
    scramble_nonce_t exp_nonce;
    @(negedge clk);
    core_busy      = r.wake[6];
    debug_req      = r.wake[5];
    irq_en         = r.wake[4];
    irq_software   = r.wake[3];
    irq_timer      = r.wake[2];
    irq_external   = r.wake[1];
    irq_nm         = r.wake[0];
    irq_fast       = r.irq_fast;
    rf_raddr_a     = r.addr;
    rf_raddr_b     = r.addr;
    rf_waddr       = r.addr;
    rf_wdata       = $random(seed);
    rf_we          = (r.op != OP_HOLD);
    key_invalidate = r.key_in[1];
    key_valid_in   = r.key_in[0];
    // x0 never changes and dropped writes leave the model alone
    if (r.op == OP_WRITE && r.addr != '0) begin
      model[r.addr] = rf_wdata;
    end
    exp_data  = model[r.addr];
    exp_key   = r.exp_out[0] ? NEW_KEY : KEY_RESET_DEFAULT;
    exp_nonce = r.exp_out[0] ? NEW_NONCE : NONCE_RESET_DEFAULT;
    @(posedge clk);
    #(SAMPLE_DELAY);
    check_value("core_sleep_o", 128'(core_sleep), 128'(r.exp_out[3]));
    check_value("scramble_req_o", 128'(scramble_req), 128'(r.exp_out[2]));
    check_value("scramble_key_valid_o", 128'(scramble_key_valid), 128'(r.exp_out[1]));
    check_value("key_o", key_out, exp_key);
    check_value("nonce_o", 128'(nonce_out), 128'(exp_nonce));
    check_value("rf_rdata_a_o", 128'(rf_rdata_a), 128'(exp_data));
    check_value("rf_rdata_b_o", 128'(rf_rdata_b), 128'(exp_data));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test table
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // Reset values
    add_row(OP_HOLD, 7'd0, '0, 5'd0, 2'b00, E_SLEEP);
    add_row(OP_HOLD, 7'd0, '0, 5'd31, 2'b00, E_SLEEP);
    // Busy is registered, so the gate is still closed on the first busy edge
    add_row(OP_DROP, W_BUSY, '0, 5'd3, 2'b00, E_AWAKE);
    // Writes with the core busy, x0 included
    add_row(OP_WRITE, W_BUSY, '0, 5'd1, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd2, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd5, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd0, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd31, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd17, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd8, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_BUSY, '0, 5'd3, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd1, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd5, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd0, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd31, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd17, 2'b00, E_AWAKE);
    // Asleep: writes dropped, masked interrupts do not wake
    add_row(OP_HOLD, 7'd0, '0, 5'd2, 2'b00, E_SLEEP);
    add_row(OP_DROP, 7'd0, '0, 5'd5, 2'b00, E_SLEEP);
    add_row(OP_DROP, W_SW | W_TIMER | W_EXT, '1, 5'd17, 2'b00, E_SLEEP);
    add_row(OP_HOLD, W_BUSY, '0, 5'd5, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_BUSY, '0, 5'd17, 2'b00, E_AWAKE);
    add_row(OP_HOLD, 7'd0, '0, 5'd8, 2'b00, E_SLEEP);
    // Direct wake sources open the gate on the same edge
    add_row(OP_WRITE, W_DEBUG, '0, 5'd9, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_NM, '0, 5'd10, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_IRQ_EN | W_SW, '0, 5'd11, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_IRQ_EN | W_TIMER, '0, 5'd12, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_IRQ_EN | W_EXT, '0, 5'd13, 2'b00, E_AWAKE);
    add_row(OP_WRITE, W_IRQ_EN, 15'h0080, 5'd14, 2'b00, E_AWAKE);
    add_row(OP_HOLD, W_IRQ_EN, '0, 5'd9, 2'b00, E_SLEEP);
    add_row(OP_DROP, W_IRQ_EN, '0, 5'd9, 2'b00, E_SLEEP);
    add_row(OP_HOLD, W_DEBUG, '0, 5'd10, 2'b00, E_AWAKE);
    // Key refresh runs on the free clock while the core sleeps
    add_row(OP_HOLD, 7'd0, '0, 5'd11, 2'b10, 4'b1100);
    add_row(OP_HOLD, 7'd0, '0, 5'd11, 2'b00, 4'b1100);
    add_row(OP_HOLD, 7'd0, '0, 5'd11, 2'b00, 4'b1100);
    add_row(OP_HOLD, 7'd0, '0, 5'd12, 2'b01, 4'b1011);
    add_row(OP_HOLD, 7'd0, '0, 5'd12, 2'b00, 4'b1011);
    add_row(OP_HOLD, 7'd0, '0, 5'd13, 2'b10, 4'b1101);
    add_row(OP_HOLD, 7'd0, '0, 5'd13, 2'b01, 4'b1011);
    add_row(OP_HOLD, 7'd0, '0, 5'd14, 2'b00, 4'b1011);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'hb38a6c37;
    cur_row        = 0;
    rows_ready     = 1'b0;
    core_busy      = 1'b0;
    debug_req      = 1'b0;
    irq_en         = 1'b0;
    irq_software   = 1'b0;
    irq_timer      = 1'b0;
    irq_external   = 1'b0;
    irq_nm         = 1'b0;
    irq_fast       = '0;
    rf_raddr_a     = '0;
    rf_raddr_b     = '0;
    rf_waddr       = '0;
    rf_wdata       = '0;
    rf_we          = 1'b0;
    key_invalidate = 1'b0;
    key_valid_in   = 1'b0;
    scramble_key   = NEW_KEY;
    scramble_nonce = NEW_NONCE;
    foreach (model[i]) begin
      model[i] = '0;
    end
    build_table();
    rows_ready = 1'b1;
    wait (rst_n === 1'b1);
    foreach (rows[i]) begin
      cur_row = i;
      apply_row(rows[i]);
    end
    $display("All checks passed");
    $finish;
  end

  // Four cycles per row plus margin for reset
  initial begin
    wait (rows_ready);
    repeat (rows.size() * 4 + 50) @(posedge clk);
    $display("Timeout: the test table did not finish in time");
    $display("Checks failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: hw/core_shell_top.sv
// Core shell top level
// Clock gate, flip-flop register file and scrambling key handshake
// with the pipeline replaced by plain register file and busy ports

`timescale 1ns/1ps

module core_shell_top import shell_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  // Clock and reset
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Wake sources
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_en_i,
  input  logic                    irq_software_i,
  input  logic                    irq_timer_i,
  input  logic                    irq_external_i,
  input  logic                    irq_nm_i,
  input  logic [NUM_FAST_IRQ-1:0] irq_fast_i,
  output logic                    core_sleep_o,

  // Register file access
  input  reg_addr_t               rf_raddr_a_i,
  input  reg_addr_t               rf_raddr_b_i,
  input  reg_addr_t               rf_waddr_i,
  input  reg_data_t               rf_wdata_i,
  input  logic                    rf_we_i,
  output reg_data_t               rf_rdata_a_o,
  output reg_data_t               rf_rdata_b_o,

  // Scrambling key interface
  input  logic                    key_invalidate_i,
  input  logic                    scramble_key_valid_i,
  input  scramble_key_t           scramble_key_i,
  input  scramble_nonce_t         scramble_nonce_i,
  output logic                    scramble_req_o,
  output logic                    scramble_key_valid_o,
  output scramble_key_t           key_o,
  output scramble_nonce_t         nonce_o
);

  // Core clock after the main gate
  logic clk_core;

  rf_port_if rf_bus ();

  //////////////////////////////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////////////////////////////

  core_sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .core_busy_i   (core_busy_i),
    .debug_req_i   (debug_req_i),
    .irq_en_i      (irq_en_i),
    .irq_software_i(irq_software_i),
    .irq_timer_i   (irq_timer_i),
    .irq_external_i(irq_external_i),
    .irq_nm_i      (irq_nm_i),
    .irq_fast_i    (irq_fast_i),
    .core_sleep_o  (core_sleep_o),
    .clk_gated_o   (clk_core)
  );

  //////////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////////

  // Top-level ports take the requester side of the bundle
  assign rf_bus.raddr_a = rf_raddr_a_i;
  assign rf_bus.raddr_b = rf_raddr_b_i;
  assign rf_bus.waddr   = rf_waddr_i;
  assign rf_bus.wdata   = rf_wdata_i;
  assign rf_bus.we      = rf_we_i;

  assign rf_rdata_a_o = rf_bus.rdata_a;
  assign rf_rdata_b_o = rf_bus.rdata_b;

  // Writes only land while the core clock runs
  register_file_ff #(
    .RV32E(RV32E)
  ) u_register_file (
    .clk_i (clk_core),
    .rst_ni(rst_ni),
    .rf    (rf_bus.regfile)
  );

  //////////////////////////////////////////////////////////////////////////
  // Scrambling key
  //////////////////////////////////////////////////////////////////////////

  // Free-running clock, a key may arrive while the core sleeps
  scramble_key_ctrl u_scramble_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .key_invalidate_i    (key_invalidate_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .key_valid_o         (scramble_key_valid_o),
    .key_o               (key_o),
    .nonce_o             (nonce_o)
  );

endmodule

// File: hw/core_sleep_ctrl.sv
// Core sleep control and main clock gate
// Keeps the core clock running while busy, in debug or with an interrupt pending

`timescale 1ns/1ps

module core_sleep_ctrl import shell_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Wake sources
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_en_i,
  input  logic                    irq_software_i,
  input  logic                    irq_timer_i,
  input  logic                    irq_external_i,
  input  logic                    irq_nm_i,
  input  logic [NUM_FAST_IRQ-1:0] irq_fast_i,

  output logic                    core_sleep_o,
  output logic                    clk_gated_o
);

  logic core_busy_q;
  logic irq_pending;
  logic clock_en;
  logic clock_en_latch;

  // Busy flag runs on the free clock so it can wake the core
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Maskable lines only count while globally enabled
  assign irq_pending = irq_en_i &
                       (irq_software_i | irq_timer_i | irq_external_i | (|irq_fast_i));

  // NMI bypasses the enable
  assign clock_en     = core_busy_q | debug_req_i | irq_pending | irq_nm_i;
  assign core_sleep_o = ~clock_en;

  //////////////////////////////////////////////////////////////////////////
  // Main clock gate
  //////////////////////////////////////////////////////////////////////////

  // Enable settles during the low phase, so the high pulse is never cut short
  always_latch begin
    if (!clk_i) begin
      clock_en_latch = clock_en;
    end
  end

  assign clk_gated_o = clk_i & clock_en_latch;

endmodule

// File: hw/register_file_ff.sv
// Flip-flop register file
// x0 reads zero, RV32E keeps only the lower sixteen registers

`timescale 1ns/1ps

module register_file_ff import shell_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  // Gated core clock
  input  logic   clk_i,
  input  logic   rst_ni,

  rf_port_if.regfile rf
);

  localparam int unsigned NUM_WORDS = RV32E ? NUM_REGS_E : NUM_REGS;

  // Full-size view so any 5-bit address selects a defined entry
  reg_data_t rf_reg [NUM_REGS];

  //////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////

  // x0 is not a flop
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < NUM_REGS; i++) begin : gen_regs
    if (i < NUM_WORDS) begin : gen_flop
      logic      wr_en;
      reg_data_t rf_reg_q;

      // One-hot write decode
      assign wr_en = rf.we & (rf.waddr == reg_addr_t'(i));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          rf_reg_q <= '0;
        end else if (wr_en) begin
          rf_reg_q <= rf.wdata;
        end
      end

      assign rf_reg[i] = rf_reg_q;
    end else begin : gen_absent
      // Not present in RV32E, reads back zero and ignores writes
      assign rf_reg[i] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////////////////////////////

  assign rf.rdata_a = rf_reg[rf.raddr_a];
  assign rf.rdata_b = rf_reg[rf.raddr_b];

endmodule

// File: hw/rf_port_if.sv
// Register file port bundle
// Two combinational read ports and one write port, no handshake

`timescale 1ns/1ps

interface rf_port_if import shell_pkg::*; ();

  // Read port A
  reg_addr_t raddr_a;
  reg_data_t rdata_a;

  // Read port B
  reg_addr_t raddr_b;
  reg_data_t rdata_b;

  // Write port, taken on the gated clock edge
  reg_addr_t waddr;
  reg_data_t wdata;
  logic      we;

  // Side that issues addresses and write data
  modport requester (
    output raddr_a, raddr_b,
    output waddr, wdata, we,
    input  rdata_a, rdata_b
  );

  // Register array side
  modport regfile (
    input  raddr_a, raddr_b,
    input  waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

// File: hw/scramble_key_ctrl.sv
// Scrambling key control
// Requests a fresh key after an invalidate and holds key and nonce

`timescale 1ns/1ps

module scramble_key_ctrl import shell_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,

  // From the instruction side
  input  logic            key_invalidate_i,

  // Key source
  input  logic            scramble_key_valid_i,
  input  scramble_key_t   scramble_key_i,
  input  scramble_nonce_t scramble_nonce_i,
  output logic            scramble_req_o,

  // To the scrambled memories
  output logic            key_valid_o,
  output scramble_key_t   key_o,
  output scramble_nonce_t nonce_o
);

  logic            req_d, req_q;
  logic            key_valid_d, key_valid_q;
  scramble_key_t   key_q;
  scramble_nonce_t nonce_q;

  //////////////////////////////////////////////////////////////////////////
  // Request and valid state
  //////////////////////////////////////////////////////////////////////////

  // Request raised by invalidate, held until a key is delivered
  assign req_d = req_q ? ~scramble_key_valid_i : key_invalidate_i;

  // Valid drops on invalidate and returns with the new key
  always_comb begin
    if (req_q) begin
      key_valid_d = scramble_key_valid_i;
    end else if (key_invalidate_i) begin
      key_valid_d = 1'b0;
    end else begin
      key_valid_d = key_valid_q;
    end
  end

  // Reset key counts as valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q       <= 1'b0;
      key_valid_q <= 1'b1;
    end else begin
      req_q       <= req_d;
      key_valid_q <= key_valid_d;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Key and nonce
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= KEY_RESET_DEFAULT;
      nonce_q <= NONCE_RESET_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign scramble_req_o = req_q;
  assign key_valid_o    = key_valid_q;
  assign key_o          = key_q;
  assign nonce_o        = nonce_q;

endmodule

// File: hw/shell_pkg.sv
// Shared definitions for the core shell
// Register file geometry, scrambling key types and their reset values

package shell_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned REG_DATA_W = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Full RV32I set and the reduced RV32E set
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned NUM_REGS_E = 16;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  //////////////////////////////////////////////////////////////////////////
  // Instruction side scrambling
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned SCRAMBLE_KEY_W   = 128;
  localparam int unsigned SCRAMBLE_NONCE_W = 64;

  typedef logic [SCRAMBLE_KEY_W-1:0]   scramble_key_t;
  typedef logic [SCRAMBLE_NONCE_W-1:0] scramble_nonce_t;

  // Used until the key source delivers the first valid key
  localparam scramble_key_t KEY_RESET_DEFAULT =
    128'h3a5c_91e7_0d2f_b846_c17e_5a09_e6d3_42b1;
  localparam scramble_nonce_t NONCE_RESET_DEFAULT =
    64'h8f14_e45f_ceea_167a;

  //////////////////////////////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_FAST_IRQ = 15;

endpackage

// File: sources.f
hw/shell_pkg.sv
hw/rf_port_if.sv
hw/register_file_ff.sv
hw/core_sleep_ctrl.sv
hw/scramble_key_ctrl.sv
hw/core_shell_top.sv
bench/tb_clock_gen.sv
bench/tb_core_shell.sv
